// ==== hw/regfile_pkg.sv ====
package regfile_pkg;

	// ====================
	// geometry
	// ====================

	// one integer register
	localparam int DATA_W = 64;
	// architectural register count
	localparam int REG_CNT = 256;
	// index width, log2 of REG_CNT
	localparam int ADDR_W = 8;

	typedef logic [ADDR_W-1:0] reg_addr_t;
	typedef logic [DATA_W-1:0] reg_data_t;

	// even index of the last pair touched by the clear sweep
	localparam reg_addr_t SWEEP_LAST_PAIR = reg_addr_t'(REG_CNT - 2);

	// ====================
	// access sequencer
	// ====================

	typedef enum logic [2:0] {
		// post-reset sweep, both write ports busy
		SEQ_CLEAR,
		// ready, no host transfer open
		SEQ_IDLE,
		// host write waiting for port 1
		SEQ_WR_WAIT,
		// port 5 address registered
		SEQ_RD,
		// one-cycle wishbone ack
		SEQ_ACK
	} seq_state_t;

endpackage

// ==== hw/regfile_2w6r_lvt.sv ====
`timescale 1ns/1ps

module regfile_2w6r_lvt (
	input  logic                   rclk,
	input  logic                   wr0,
	input  logic                   wr1,
	input  regfile_pkg::reg_addr_t wa0,
	input  regfile_pkg::reg_addr_t wa1,
	input  regfile_pkg::reg_data_t i0,
	input  regfile_pkg::reg_data_t i1,
	input  regfile_pkg::reg_addr_t ra0,
	input  regfile_pkg::reg_addr_t ra1,
	input  regfile_pkg::reg_addr_t ra2,
	input  regfile_pkg::reg_addr_t ra3,
	input  regfile_pkg::reg_addr_t ra4,
	input  regfile_pkg::reg_addr_t ra5,
	output regfile_pkg::reg_data_t o0,
	output regfile_pkg::reg_data_t o1,
	output regfile_pkg::reg_data_t o2,
	output regfile_pkg::reg_data_t o3,
	output regfile_pkg::reg_data_t o4,
	output regfile_pkg::reg_data_t o5
);
	import regfile_pkg::*;

	// one bank per write port, each bank only ever written by its own port
	reg_data_t bank0 [REG_CNT];
	reg_data_t bank1 [REG_CNT];

	// live-value table
	// 0 means bank0 holds the newest copy, 1 means bank1
	logic lvt [REG_CNT];

	// registered read addresses
	reg_addr_t rra0;
	reg_addr_t rra1;
	reg_addr_t rra2;
	reg_addr_t rra3;
	reg_addr_t rra4;
	reg_addr_t rra5;

	// ====================
	// write side
	// ====================

	always_ff @(posedge rclk) begin
		if (wr0)
			bank0[wa0] <= i0;
	end

	always_ff @(posedge rclk) begin
		if (wr1)
			bank1[wa1] <= i1;
	end

	// port 1 update comes last, so on a same-address collision it wins
	always_ff @(posedge rclk) begin
		if (wr0)
			lvt[wa0] <= 1'b0;
		if (wr1)
			lvt[wa1] <= 1'b1;
	end

	// ====================
	// read side
	// ====================

	always_ff @(posedge rclk) begin
		rra0 <= ra0;
		rra1 <= ra1;
		rra2 <= ra2;
		rra3 <= ra3;
		rra4 <= ra4;
		rra5 <= ra5;
	end

	// one read lane: r0 is hardwired, then bypass from this cycle's
	// writes (port 1 first), then whichever bank the table points at
	function automatic reg_data_t rd_lane(input reg_addr_t ra);
		if (ra == '0)
			return '0;
		if (wr1 && (ra == wa1))
			return i1;
		if (wr0 && (ra == wa0))
			return i0;
		return lvt[ra] ? bank1[ra] : bank0[ra];
	endfunction

	always_comb begin
		o0 = rd_lane(rra0);
		o1 = rd_lane(rra1);
		o2 = rd_lane(rra2);
		o3 = rd_lane(rra3);
		o4 = rd_lane(rra4);
		// port 5 belongs to the wishbone host
		o5 = rd_lane(rra5);
	end

endmodule

// ==== hw/clear_sweep_counter.sv ====
`timescale 1ns/1ps

module clear_sweep_counter (
	input  logic                   rclk,
	input  logic                   rst_n,
	input  logic                   sweep_en,
	output regfile_pkg::reg_addr_t sweep_idx,
	output logic                   sweep_done
);
	import regfile_pkg::*;

	// sweep_idx is always the even member of the pair,
	// the odd one is formed by the sequencer
	assign sweep_done = (sweep_idx == SWEEP_LAST_PAIR);

	// two registers per step, parks on the last pair
	always_ff @(posedge rclk) begin
		if (!rst_n) begin
			sweep_idx <= '0;
		end else if (sweep_en && !sweep_done) begin
			sweep_idx <= sweep_idx + reg_addr_t'(2);
		end
	end

	// ====================
	// checks
	// ====================

	// once the last pair is out the sequencer stops stepping,
	// so the index stays parked on the last pair
	a_idx_parked: assert property (
		@(posedge rclk) disable iff (!rst_n)
		sweep_done |=> !sweep_en
	);

endmodule

// ==== hw/regfile_access_seq.sv ====
`timescale 1ns/1ps

module regfile_access_seq (
	input  logic                   rclk,
	input  logic                   rst_n,
	input  logic                   sweep_done,
	input  regfile_pkg::reg_addr_t sweep_idx,
	output logic                   sweep_en,
	input  logic                   cm_wr0,
	input  logic                   cm_wr1,
	input  regfile_pkg::reg_addr_t cm_wa0,
	input  regfile_pkg::reg_addr_t cm_wa1,
	input  regfile_pkg::reg_data_t cm_i0,
	input  regfile_pkg::reg_data_t cm_i1,
	input  logic                   wb_cyc,
	input  logic                   wb_stb,
	input  logic                   wb_we,
	input  regfile_pkg::reg_addr_t wb_adr,
	input  regfile_pkg::reg_data_t wb_dat_w,
	output logic                   wb_ack,
	output logic                   rf_wr0,
	output logic                   rf_wr1,
	output regfile_pkg::reg_addr_t rf_wa0,
	output regfile_pkg::reg_addr_t rf_wa1,
	output regfile_pkg::reg_data_t rf_i0,
	output regfile_pkg::reg_data_t rf_i1,
	output regfile_pkg::reg_addr_t rf_ra5,
	output logic                   ready
);
	import regfile_pkg::*;

	seq_state_t state;
	seq_state_t state_nxt;

	// host has a transfer open on the bus
	logic host_req;
	// host write lands on port 1 this cycle
	logic host_wr;

	assign host_req = wb_cyc && wb_stb;
	assign ready = (state != SEQ_CLEAR);
	assign wb_ack = (state == SEQ_ACK);

	// commit port 1 has priority, host only fills idle slots
	// address and data come straight off the bus, the host holds them until ack
	assign host_wr = !cm_wr1 &&
		(((state == SEQ_IDLE) && host_req && wb_we) || (state == SEQ_WR_WAIT));

	// port 5 follows the bus address, stable for the whole transfer
	assign rf_ra5 = wb_adr;

	// ====================
	// state machine
	// ====================

	always_comb begin
		state_nxt = state;
		case (state)
			SEQ_CLEAR: begin
				if (sweep_done)
					state_nxt = SEQ_IDLE;
			end
			SEQ_IDLE: begin
				if (host_req && wb_we)
					state_nxt = cm_wr1 ? SEQ_WR_WAIT : SEQ_ACK;
				else if (host_req)
					state_nxt = SEQ_RD;
			end
			SEQ_WR_WAIT: begin
				// write goes out in the first cycle commit leaves port 1 free
				if (!cm_wr1)
					state_nxt = SEQ_ACK;
			end
			// read data is on o5 from here on
			SEQ_RD:  state_nxt = SEQ_ACK;
			SEQ_ACK: state_nxt = SEQ_IDLE;
			default: state_nxt = SEQ_IDLE;
		endcase
	end

	// sweep_en is a flop so the write ports stay quiet through reset
	// and the first sweep write lands on the cycle after release
	always_ff @(posedge rclk) begin
		if (!rst_n) begin
			state <= SEQ_CLEAR;
			sweep_en <= 1'b0;
		end else begin
			state <= state_nxt;
			sweep_en <= (state_nxt == SEQ_CLEAR);
		end
	end

	// ====================
	// write port steering
	// ====================

	always_comb begin
		if (sweep_en) begin
			// zero the even/odd pair together
			rf_wr0 = 1'b1;
			rf_wa0 = sweep_idx;
			rf_i0 = '0;
			rf_wr1 = 1'b1;
			rf_wa1 = {sweep_idx[ADDR_W-1:1], 1'b1};
			rf_i1 = '0;
		end else begin
			rf_wr0 = ready && cm_wr0;
			rf_wa0 = cm_wa0;
			rf_i0 = cm_i0;
			rf_wr1 = (ready && cm_wr1) || host_wr;
			rf_wa1 = cm_wr1 ? cm_wa1 : wb_adr;
			rf_i1 = cm_wr1 ? cm_i1 : wb_dat_w;
		end
	end

	// ====================
	// checks
	// ====================

	// commit stage must hold off until the sweep has finished
	a_no_commit_before_ready: assert property (
		@(posedge rclk) disable iff (!rst_n)
		!ready |-> !(cm_wr0 || cm_wr1)
	);

	// host drops stb right after its ack, so a transfer sees a single ack
	a_stb_drop_after_ack: assert property (
		@(posedge rclk) disable iff (!rst_n)
		wb_ack |=> !wb_stb
	);

endmodule

// ==== hw/regfile_subsys.sv ====
`timescale 1ns/1ps

module regfile_subsys (
	input  logic                   rclk,
	input  logic                   rst_n,
	input  logic                   wr0,
	input  logic                   wr1,
	input  regfile_pkg::reg_addr_t wa0,
	input  regfile_pkg::reg_addr_t wa1,
	input  regfile_pkg::reg_data_t i0,
	input  regfile_pkg::reg_data_t i1,
	input  regfile_pkg::reg_addr_t ra0,
	input  regfile_pkg::reg_addr_t ra1,
	input  regfile_pkg::reg_addr_t ra2,
	input  regfile_pkg::reg_addr_t ra3,
	input  regfile_pkg::reg_addr_t ra4,
	output regfile_pkg::reg_data_t o0,
	output regfile_pkg::reg_data_t o1,
	output regfile_pkg::reg_data_t o2,
	output regfile_pkg::reg_data_t o3,
	output regfile_pkg::reg_data_t o4,
	input  logic                   wb_cyc,
	input  logic                   wb_stb,
	input  logic                   wb_we,
	input  regfile_pkg::reg_addr_t wb_adr,
	input  regfile_pkg::reg_data_t wb_dat_w,
	output regfile_pkg::reg_data_t wb_dat_r,
	output logic                   wb_ack,
	output logic                   ready
);
	import regfile_pkg::*;

	// sweep control
	logic      sweep_en;
	logic      sweep_done;
	reg_addr_t sweep_idx;

	// steered write ports and host read address
	logic      rf_wr0;
	logic      rf_wr1;
	reg_addr_t rf_wa0;
	reg_addr_t rf_wa1;
	reg_data_t rf_i0;
	reg_data_t rf_i1;
	reg_addr_t rf_ra5;

	clear_sweep_counter clear_sweep_counter_i (
		.rclk       (rclk),
		.rst_n      (rst_n),
		.sweep_en   (sweep_en),
		.sweep_idx  (sweep_idx),
		.sweep_done (sweep_done)
	);

	regfile_access_seq regfile_access_seq_i (
		.rclk       (rclk),
		.rst_n      (rst_n),
		.sweep_done (sweep_done),
		.sweep_idx  (sweep_idx),
		.sweep_en   (sweep_en),
		.cm_wr0     (wr0),
		.cm_wr1     (wr1),
		.cm_wa0     (wa0),
		.cm_wa1     (wa1),
		.cm_i0      (i0),
		.cm_i1      (i1),
		.wb_cyc     (wb_cyc),
		.wb_stb     (wb_stb),
		.wb_we      (wb_we),
		.wb_adr     (wb_adr),
		.wb_dat_w   (wb_dat_w),
		.wb_ack     (wb_ack),
		.rf_wr0     (rf_wr0),
		.rf_wr1     (rf_wr1),
		.rf_wa0     (rf_wa0),
		.rf_wa1     (rf_wa1),
		.rf_i0      (rf_i0),
		.rf_i1      (rf_i1),
		.rf_ra5     (rf_ra5),
		.ready      (ready)
	);

	// pipeline reads go straight in, port 5 serves the host
	regfile_2w6r_lvt regfile_2w6r_lvt_i (
		.rclk (rclk),
		.wr0  (rf_wr0),
		.wr1  (rf_wr1),
		.wa0  (rf_wa0),
		.wa1  (rf_wa1),
		.i0   (rf_i0),
		.i1   (rf_i1),
		.ra0  (ra0),
		.ra1  (ra1),
		.ra2  (ra2),
		.ra3  (ra3),
		.ra4  (ra4),
		.ra5  (rf_ra5),
		.o0   (o0),
		.o1   (o1),
		.o2   (o2),
		.o3   (o3),
		.o4   (o4),
		.o5   (wb_dat_r)
	);

endmodule

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
	output logic rclk,
	output logic rst_n
);
	// half of the 40 ns period
	localparam int HALF_PERIOD = 20;
	localparam int RST_CYCLES = 5;

	initial begin
		rclk = 1'b0;
		forever #HALF_PERIOD rclk = ~rclk;
	end

	// synchronous reset, let go on a rising edge
	initial begin
		rst_n <= 1'b0;
		repeat (RST_CYCLES) @(posedge rclk);
		rst_n <= 1'b1;
	end

endmodule

// ==== verification/tb_regfile_subsys.sv ====
`timescale 1ns/1ps

module tb_regfile_subsys;
	import regfile_pkg::*;

	// ====================
	// run length
	// ====================

	localparam int N_RAND = 300;
	localparam int N_COLL = 16;
	localparam int N_WB = 24;
	// longest wait for one wishbone ack
	localparam int ACK_LIMIT = 64;
	// reset, sweep and every test, doubled as margin
	localparam int WD_CYCLES = 2 * (5 + REG_CNT / 2 + REG_CNT / 5 + N_RAND + 3 * N_COLL
		+ 16 + 2 * (N_WB + 2) * ACK_LIMIT + N_WB);

	logic      rclk;
	logic      rst_n;
	logic      wr0;
	logic      wr1;
	reg_addr_t wa0;
	reg_addr_t wa1;
	reg_data_t i0;
	reg_data_t i1;
	reg_addr_t ra [5];
	reg_data_t o [5];
	logic      wb_cyc;
	logic      wb_stb;
	logic      wb_we;
	reg_addr_t wb_adr;
	reg_data_t wb_dat_w;
	reg_data_t wb_dat_r;
	logic      wb_ack;
	logic      ready;

	// stimulus for the coming cycle, driven at the next rising edge
	logic      n_wr0;
	logic      n_wr1;
	reg_addr_t n_wa0;
	reg_addr_t n_wa1;
	reg_data_t n_i0;
	reg_data_t n_i1;
	reg_addr_t n_ra [5];
	logic      n_cyc;
	logic      n_stb;
	logic      n_we;
	reg_addr_t n_adr;
	reg_data_t n_dat;

	// reference contents, r0 is never written
	reg_data_t model [REG_CNT];
	// read addresses presented one cycle back
	reg_addr_t p_ra [5];
	logic      p_valid;
	reg_addr_t wq [$];

	logic [31:0] seed = 32'hd8d5_a8bb;
	int errors = 0;
	int checks = 0;
	int tests_run = 0;

	tb_clock_gen clk_gen_i (
		.rclk  (rclk),
		.rst_n (rst_n)
	);

	regfile_subsys regfile_subsys_i (
		.ra0 (ra[0]),
		.ra1 (ra[1]),
		.ra2 (ra[2]),
		.ra3 (ra[3]),
		.ra4 (ra[4]),
		.o0  (o[0]),
		.o1  (o[1]),
		.o2  (o[2]),
		.o3  (o[3]),
		.o4  (o[4]),
		.*
	);

	// ====================
	// random source
	// ====================

	function automatic logic [31:0] next_rand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic reg_addr_t rand_addr();
		logic [31:0] r;
		r = next_rand();
		return r[23:16];
	endfunction

	function automatic reg_data_t rand_data();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = next_rand();
		lo = next_rand();
		return {hi, lo};
	endfunction

	function automatic logic rand_bit();
		logic [31:0] r;
		r = next_rand();
		return r[30];
	endfunction

	// ====================
	// cycle engine
	// ====================

	task automatic quiet();
		n_wr0 = 1'b0;
		n_wr1 = 1'b0;
	endtask

	task automatic set_reads(input reg_addr_t a);
		for (int k = 0; k < 5; k++)
			n_ra[k] = a;
	endtask

	// random commit writes and reads inside mask
	// avoid is kept off the commit ports and the pipeline reads
	task automatic commit_traffic(input reg_addr_t mask, input reg_addr_t avoid);
		n_wr0 = rand_bit();
		n_wr1 = rand_bit();
		n_wa0 = rand_addr() & mask;
		n_wa1 = rand_addr() & mask;
		if (n_wa0 == avoid)
			n_wa0 = avoid ^ 8'h01;
		if (n_wa1 == avoid)
			n_wa1 = avoid ^ 8'h01;
		n_i0 = rand_data();
		n_i1 = rand_data();
		for (int k = 0; k < 5; k++) begin
			n_ra[k] = rand_addr() & mask;
			if (n_ra[k] == avoid)
				n_ra[k] = '0;
		end
	endtask

	task automatic tick();
		@(posedge rclk);
		wr0 <= n_wr0;
		wr1 <= n_wr1;
		wa0 <= n_wa0;
		wa1 <= n_wa1;
		i0 <= n_i0;
		i1 <= n_i1;
		wb_cyc <= n_cyc;
		wb_stb <= n_stb;
		wb_we <= n_we;
		wb_adr <= n_adr;
		wb_dat_w <= n_dat;
		for (int k = 0; k < 5; k++)
			ra[k] <= n_ra[k];
		@(negedge rclk);
		// this cycle's writes already show through the bypass
		// port 1 goes last so it wins a collision
		if (n_wr0 && n_wa0 != '0)
			model[n_wa0] = n_i0;
		if (n_wr1 && n_wa1 != '0)
			model[n_wa1] = n_i1;
		if (p_valid) begin
			for (int k = 0; k < 5; k++) begin
				checks++;
				if (o[k] !== model[p_ra[k]]) begin
					$display("Error at %0t: port %0d reg %0d read %h, expected %h",
						$time, k, p_ra[k], o[k], model[p_ra[k]]);
					errors++;
				end
			end
		end
		p_ra = n_ra;
		p_valid = 1'b1;
	endtask

	// ====================
	// wishbone host
	// ====================

	// host holds the request while commit traffic runs beside it
	task automatic wait_ack(input reg_addr_t a, output int waited);
		waited = 0;
		do begin
			commit_traffic(8'hff, a);
			tick();
			waited++;
		end while (wb_ack !== 1'b1 && waited < ACK_LIMIT);
		if (wb_ack !== 1'b1) begin
			$display("wishbone transfer to reg %0d got no ack within %0d cycles",
				a, ACK_LIMIT);
			errors++;
		end
	endtask

	// drop stb after the ack, ack must be gone the next cycle
	task automatic end_transfer();
		n_cyc = 1'b0;
		n_stb = 1'b0;
		n_we = 1'b0;
		quiet();
		set_reads('0);
		tick();
		checks++;
		if (wb_ack !== 1'b0) begin
			$display("Error at %0t: wb_ack high for a second cycle", $time);
			errors++;
		end
	endtask

	task automatic wb_write(input reg_addr_t a, input reg_data_t d);
		int waited;
		n_cyc = 1'b1;
		n_stb = 1'b1;
		n_we = 1'b1;
		n_adr = a;
		n_dat = d;
		wait_ack(a, waited);
		if (wb_ack === 1'b1 && a != '0)
			model[a] = d;
		end_transfer();
	endtask

	task automatic wb_read(input reg_addr_t a);
		int waited;
		n_cyc = 1'b1;
		n_stb = 1'b1;
		n_we = 1'b0;
		n_adr = a;
		wait_ack(a, waited);
		if (wb_ack === 1'b1) begin
			checks++;
			// request cycle, address capture, then ack
			if (waited != 3) begin
				$display("Error at %0t: wb read ack after %0d cycles, expected 3",
					$time, waited);
				errors++;
			end
			if (wb_dat_r !== model[a]) begin
				$display("Error at %0t: wb read reg %0d returned %h, expected %h",
					$time, a, wb_dat_r, model[a]);
				errors++;
			end
		end
		end_transfer();
	endtask

	task automatic report_test(input string name, input int err_base);
		tests_run++;
		if (errors == err_base)
			$display("test %0d %s: passed", tests_run, name);
		else
			$display("test %0d %s: failed, %0d mismatches", tests_run, name,
				errors - err_base);
	endtask

	// ====================
	// watchdog
	// ====================

	initial begin
		repeat (WD_CYCLES) @(posedge rclk);
		$display("Timeout: run did not complete within %0d clock cycles", WD_CYCLES);
		$display("Errors found");
		$finish;
	end

	// ====================
	// tests
	// ====================

	initial begin
		int e;
		int sweep_cycles;
		reg_addr_t a;
		wr0 <= 1'b0;
		wr1 <= 1'b0;
		wa0 <= '0;
		wa1 <= '0;
		i0 <= '0;
		i1 <= '0;
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we <= 1'b0;
		wb_adr <= '0;
		wb_dat_w <= '0;
		for (int k = 0; k < 5; k++)
			ra[k] <= '0;
		quiet();
		n_wa0 = '0;
		n_wa1 = '0;
		n_i0 = '0;
		n_i1 = '0;
		set_reads('0);
		n_cyc = 1'b0;
		n_stb = 1'b0;
		n_we = 1'b0;
		n_adr = '0;
		n_dat = '0;
		p_valid = 1'b0;
		for (int j = 0; j < REG_CNT; j++)
			model[j] = '0;

		// sweep length counted from the cycle reset is released
		// watchdog covers a sweep that never ends
		e = errors;
		@(negedge rclk);
		while (rst_n !== 1'b1)
			@(negedge rclk);
		sweep_cycles = 0;
		while (ready !== 1'b1) begin
			if (wb_ack !== 1'b0) begin
				$display("Error at %0t: wb_ack high during the clear sweep", $time);
				errors++;
			end
			@(negedge rclk);
			sweep_cycles++;
		end
		// the release cycle, then one cycle per register pair
		checks++;
		if (sweep_cycles != 1 + REG_CNT / 2) begin
			$display("Error at %0t: ready after %0d cycles, expected %0d",
				$time, sweep_cycles, 1 + REG_CNT / 2);
			errors++;
		end

		// every register cleared by the sweep
		for (int base = 0; base < REG_CNT; base += 5) begin
			for (int k = 0; k < 5; k++)
				n_ra[k] = reg_addr_t'(base + k);
			tick();
		end
		set_reads('0);
		tick();
		report_test("clear sweep", e);

		// small address window so reads often hit fresh writes
		e = errors;
		for (int n = 0; n < N_RAND; n++) begin
			commit_traffic(8'h3f, 8'hff);
			tick();
		end
		quiet();
		tick();
		report_test("random commit traffic", e);

		// same address on both ports, read in that cycle and after
		e = errors;
		for (int n = 0; n < N_COLL; n++) begin
			a = rand_addr();
			if (a == '0)
				a = 8'h80;
			quiet();
			set_reads(a);
			tick();
			n_wr0 = 1'b1;
			n_wr1 = 1'b1;
			n_wa0 = a;
			n_wa1 = a;
			n_i0 = rand_data();
			n_i1 = rand_data();
			tick();
			quiet();
			tick();
		end
		report_test("same-address dual writes", e);

		// r0 through port 0, port 1, both, then the host
		e = errors;
		quiet();
		set_reads('0);
		tick();
		n_wr0 = 1'b1;
		n_wa0 = '0;
		n_i0 = rand_data();
		tick();
		quiet();
		n_wr1 = 1'b1;
		n_wa1 = '0;
		n_i1 = rand_data();
		tick();
		n_wr0 = 1'b1;
		tick();
		quiet();
		tick();
		wb_write('0, rand_data());
		wb_read('0);
		report_test("register 0 writes", e);

		// host writes under port 1 back-pressure, then read back both ways
		e = errors;
		for (int n = 0; n < N_WB; n++) begin
			a = rand_addr();
			wb_write(a, rand_data());
			wb_read(a);
			wq.push_back(a);
		end
		quiet();
		for (int j = 0; j < wq.size(); j++) begin
			for (int k = 0; k < 5; k++)
				n_ra[k] = wq[(j + k) % wq.size()];
			tick();
		end
		set_reads('0);
		tick();
		report_test("wishbone access", e);

		$display("tests run %0d, checks %0d, errors %0d", tests_run, checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// ==== sim.f ====
hw/regfile_pkg.sv
hw/regfile_2w6r_lvt.sv
hw/clear_sweep_counter.sv
hw/regfile_access_seq.sv
hw/regfile_subsys.sv
verification/tb_clock_gen.sv
verification/tb_regfile_subsys.sv

// ==== Makefile ====
TOP := tb_regfile_subsys

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir
